/* rtl/motor_regs_pkg.sv */
// Address map, field widths and packed register layouts
// Host bus struct shared by every register block
package motor_regs_pkg;

    typedef logic [5:0]  addr_t;   // Register address
    typedef logic [7:0]  data_t;   // Register byte
    typedef logic [11:0] angle_t;  // Rotation angle, 12 bit encoder
    typedef logic [5:0]  temp_t;   // ADC temperature reading
    typedef logic [4:0]  pwm_t;    // Drive PWM ratio

    // Host bus, single-cycle strobes, no handshake
    typedef struct packed {
        logic  write_en;
        logic  read_en;
        addr_t address;
        data_t wr_data;
    } reg_bus_t;

    // Drive control byte
    typedef struct packed {
        logic brake;
        logic enable;
        logic direction;
        pwm_t pwm;
    } drive_ctrl_t;

    // Drive status byte, sampled from the motor
    typedef struct packed {
        logic  fault;
        logic  startup_fail;
        temp_t temp;
    } drive_status_t;

    // Rotation control byte
    typedef struct packed {
        logic       brake;
        logic       enable;
        logic       direction;
        logic       startup_fail;  // Read only, follows the motor
        logic [3:0] target_hi;     // Target angle bits 11:8
    } rot_ctrl_t;

    // Channel count limits
    localparam int MAX_DRIVE = 4;
    localparam int MAX_ROT   = 4;

    // Broadcast addresses, 0x00 is reserved
    localparam addr_t ADDR_BCAST_ALL   = 6'h01;  // Drive and rotation
    localparam addr_t ADDR_BCAST_ROT   = 6'h02;
    localparam addr_t ADDR_BCAST_DRIVE = 6'h03;

    // Drive channels: control, status
    localparam addr_t DRIVE_BASE   = 6'h04;
    localparam int    DRIVE_STRIDE = 2;

    // Rotation channels: control, target low, angle low, command/angle high
    localparam addr_t ROT_BASE   = 6'h0C;
    localparam int    ROT_STRIDE = 4;

    // Servo, LED and debug block
    localparam addr_t ADDR_SERVO_CTRL = 6'h20;
    localparam addr_t SERVO_POS_BASE  = 6'h21;
    localparam int    NUM_SERVO       = 4;
    localparam addr_t ADDR_LED        = 6'h28;
    localparam addr_t DEBUG_BASE      = 6'h2C;
    localparam int    DEBUG_BYTES     = 4;

    // Command register bit positions
    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;
    localparam int CMD_SNAP_BIT   = 6;

endpackage

/* rtl/drive_channel.sv */
`timescale 1ns/1ns
// One drive motor channel
// Control register with broadcast decode, status sampled every clock
module drive_channel #(
    parameter int CHANNEL = 0                         // Drive index, picks the address pair
) (
    input  logic                        clock,
    input  logic                        reset,
    input  motor_regs_pkg::reg_bus_t    bus,
    input  logic                        fault,         // Motor fault
    input  logic                        startup_fail,  // Motor failed to start
    input  motor_regs_pkg::temp_t       temp,          // ADC temperature
    output motor_regs_pkg::drive_ctrl_t ctrl,
    output motor_regs_pkg::data_t       rd_value       // Zero unless our address
);
    import motor_regs_pkg::*;

    localparam addr_t CTRL_ADDR = addr_t'(DRIVE_BASE + DRIVE_STRIDE * CHANNEL);
    localparam addr_t STAT_ADDR = addr_t'(CTRL_ADDR + 1);

    drive_ctrl_t   ctrl_q;
    drive_status_t status_q;
    logic          ctrl_we;

    // Own address or either drive broadcast
    assign ctrl_we = bus.write_en &&
                     (bus.address == CTRL_ADDR ||
                      bus.address == ADDR_BCAST_DRIVE ||
                      bus.address == ADDR_BCAST_ALL);

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (ctrl_we) begin
            ctrl_q <= drive_ctrl_t'(bus.wr_data);
        end
    end

    // Status has no write path
    always_ff @(posedge clock) begin
        status_q.fault        <= fault;
        status_q.startup_fail <= startup_fail;
        status_q.temp         <= temp;
    end

    assign ctrl = ctrl_q;  // Brake, enable, direction, pwm to the bridge

    // Read mux
    always_comb begin
        rd_value = '0;
        if (bus.address == CTRL_ADDR) begin
            rd_value = data_t'(ctrl_q);
        end else if (bus.address == STAT_ADDR) begin
            rd_value = data_t'(status_q);
        end
    end

endmodule

/* rtl/rotation_channel.sv */
`timescale 1ns/1ns
// One rotation motor channel
// Control and target registers, angle snapshot, update and abort pulses
module rotation_channel #(
    parameter int CHANNEL = 0                          // Rotation index, picks the address block
) (
    input  logic                        clock,
    input  logic                        reset,
    input  motor_regs_pkg::reg_bus_t    bus,
    input  logic                        startup_fail,   // Motor stalled at startup
    input  motor_regs_pkg::angle_t      current_angle,  // Live encoder angle
    input  logic                        angle_done,     // Arrived at target
    output motor_regs_pkg::rot_ctrl_t   ctrl,
    output motor_regs_pkg::angle_t      target_angle,
    output logic                        update_angle,   // One-cycle start pulse
    output logic                        abort_angle,    // One-cycle abort pulse
    output motor_regs_pkg::data_t       rd_value        // Zero unless our address
);
    import motor_regs_pkg::*;

    localparam addr_t CTRL_ADDR   = addr_t'(ROT_BASE + ROT_STRIDE * CHANNEL);
    localparam addr_t TARGET_ADDR = addr_t'(CTRL_ADDR + 1);
    localparam addr_t ANGLE_ADDR  = addr_t'(CTRL_ADDR + 2);  // Snapshot low byte
    localparam addr_t CMD_ADDR    = addr_t'(CTRL_ADDR + 3);  // Write command, read high

    rot_ctrl_t ctrl_q;
    data_t     target_lo_q;
    angle_t    snap_q;
    logic      ctrl_we;
    logic      target_we;
    logic      cmd_we;

    assign ctrl_we = bus.write_en &&
                     (bus.address == CTRL_ADDR ||
                      bus.address == ADDR_BCAST_ROT ||
                      bus.address == ADDR_BCAST_ALL);
    assign target_we = bus.write_en && bus.address == TARGET_ADDR;
    assign cmd_we    = bus.write_en && bus.address == CMD_ADDR;

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_q <= '0;
        end else begin
            if (ctrl_we) begin
                ctrl_q <= rot_ctrl_t'(bus.wr_data);
            end
            ctrl_q.startup_fail <= startup_fail;  // Overrides the written bit
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            target_lo_q <= '0;
        end else if (target_we) begin
            target_lo_q <= bus.wr_data;
        end
    end

    // Command register stores nothing, only acts
    always_ff @(posedge clock) begin
        if (reset) begin
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
            snap_q       <= '0;
        end else begin
            update_angle <= cmd_we && bus.wr_data[CMD_UPDATE_BIT];
            abort_angle  <= cmd_we && bus.wr_data[CMD_ABORT_BIT];
            // Freeze the angle so low and high reads stay coherent
            if (cmd_we && bus.wr_data[CMD_SNAP_BIT]) begin
                snap_q <= current_angle;
            end
        end
    end

    assign ctrl         = ctrl_q;
    assign target_angle = {ctrl_q.target_hi, target_lo_q};

    always_comb begin
        rd_value = '0;
        case (bus.address)
            CTRL_ADDR:   rd_value = data_t'(ctrl_q);
            TARGET_ADDR: rd_value = target_lo_q;
            ANGLE_ADDR:  rd_value = snap_q[7:0];
            CMD_ADDR:    rd_value = {angle_done, 3'b000, snap_q[11:8]};  // Done flag live
            default:     rd_value = '0;
        endcase
    end

endmodule

/* rtl/servo_led_regs.sv */
`timescale 1ns/1ns
// Servo control and position registers, LED register
// Debug word sampled every clock and read back byte-wise
module servo_led_regs (
    input  logic                              clock,
    input  logic                              reset,
    input  motor_regs_pkg::reg_bus_t          bus,
    input  logic [31:0]                       debug_signals,
    output motor_regs_pkg::data_t             servo_control,
    output motor_regs_pkg::data_t [3:0]       servo_position,
    output logic                              led_test_enable,
    output logic                              motor_hot_led,
    output logic                              ps4_connected_led,
    output logic                              pi_connected_led,
    output logic                              fault_led,
    output motor_regs_pkg::data_t             rd_value
);
    import motor_regs_pkg::*;

    data_t                      servo_ctrl_q;
    data_t [NUM_SERVO-1:0]      servo_pos_q;
    data_t                      led_q;        // Bits 7:5 stored, unused
    logic  [8*DEBUG_BYTES-1:0]  debug_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            servo_ctrl_q <= '0;
            servo_pos_q  <= '0;
            led_q        <= '0;
        end else if (bus.write_en) begin
            if (bus.address == ADDR_SERVO_CTRL) begin
                servo_ctrl_q <= bus.wr_data;
            end
            for (int i = 0; i < NUM_SERVO; i++) begin
                if (bus.address == addr_t'(SERVO_POS_BASE + i)) begin
                    servo_pos_q[i] <= bus.wr_data;
                end
            end
            if (bus.address == ADDR_LED) begin
                led_q <= bus.wr_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        debug_q <= debug_signals;  // Free-running sample
    end

    assign servo_control     = servo_ctrl_q;
    assign servo_position    = servo_pos_q;
    assign led_test_enable   = led_q[4];
    assign motor_hot_led     = led_q[3];
    assign ps4_connected_led = led_q[2];
    assign pi_connected_led  = led_q[1];
    assign fault_led         = led_q[0];

    // Read mux, address ranges do not overlap
    always_comb begin
        rd_value = '0;
        if (bus.address == ADDR_SERVO_CTRL) begin
            rd_value = servo_ctrl_q;
        end
        if (bus.address == ADDR_LED) begin
            rd_value = led_q;
        end
        for (int i = 0; i < NUM_SERVO; i++) begin
            if (bus.address == addr_t'(SERVO_POS_BASE + i)) begin
                rd_value = servo_pos_q[i];
            end
        end
        for (int i = 0; i < DEBUG_BYTES; i++) begin
            if (bus.address == addr_t'(DEBUG_BASE + i)) begin
                rd_value = debug_q[8*i +: 8];  // Byte 0 at the base
            end
        end
    end

endmodule

/* rtl/motor_regs.sv */
`timescale 1ns/1ns
// Motor board register file top level
// Drive and rotation channel arrays, servo/LED block, registered read data
module motor_regs #(
    parameter int NUM_DRIVE = 4,                  // Up to MAX_DRIVE
    parameter int NUM_ROT   = 2                   // Up to MAX_ROT
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  motor_regs_pkg::reg_bus_t                  bus,
    output motor_regs_pkg::data_t                     rd_data,
    // Drive motors
    input  logic [NUM_DRIVE-1:0]                      drive_fault,
    input  logic [NUM_DRIVE-1:0]                      drive_startup_fail,
    input  motor_regs_pkg::temp_t [NUM_DRIVE-1:0]     drive_temp,
    output motor_regs_pkg::drive_ctrl_t [NUM_DRIVE-1:0] drive_ctrl,
    // Rotation motors
    input  logic [NUM_ROT-1:0]                        rot_startup_fail,
    input  motor_regs_pkg::angle_t [NUM_ROT-1:0]      current_angle,
    input  logic [NUM_ROT-1:0]                        angle_done,
    output motor_regs_pkg::rot_ctrl_t [NUM_ROT-1:0]   rot_ctrl,
    output motor_regs_pkg::angle_t [NUM_ROT-1:0]      target_angle,
    output logic [NUM_ROT-1:0]                        update_angle,
    output logic [NUM_ROT-1:0]                        abort_angle,
    // Servo, LED and debug
    input  logic [31:0]                               debug_signals,
    output motor_regs_pkg::data_t                     servo_control,
    output motor_regs_pkg::data_t [3:0]               servo_position,
    output logic                                      led_test_enable,
    output logic                                      motor_hot_led,
    output logic                                      ps4_connected_led,
    output logic                                      pi_connected_led,
    output logic                                      fault_led
);
    import motor_regs_pkg::*;

    data_t [NUM_DRIVE-1:0] drive_rd;   // Per-channel read values
    data_t [NUM_ROT-1:0]   rot_rd;
    data_t                 servo_rd;
    data_t                 rd_next;    // OR of all blocks

    // Channel counts beyond the address map would alias
    if (NUM_DRIVE > MAX_DRIVE || NUM_ROT > MAX_ROT) begin : g_count_check
        $error("motor_regs: channel count exceeds the address map");
    end

    for (genvar i = 0; i < NUM_DRIVE; i++) begin : g_drive
        drive_channel #(
            .CHANNEL(i)
        ) drive_i (
            .clock       (clock),
            .reset       (reset),
            .bus         (bus),
            .fault       (drive_fault[i]),
            .startup_fail(drive_startup_fail[i]),
            .temp        (drive_temp[i]),
            .ctrl        (drive_ctrl[i]),
            .rd_value    (drive_rd[i])
        );
    end

    for (genvar i = 0; i < NUM_ROT; i++) begin : g_rot
        rotation_channel #(
            .CHANNEL(i)
        ) rot_i (
            .clock        (clock),
            .reset        (reset),
            .bus          (bus),
            .startup_fail (rot_startup_fail[i]),
            .current_angle(current_angle[i]),
            .angle_done   (angle_done[i]),
            .ctrl         (rot_ctrl[i]),
            .target_angle (target_angle[i]),
            .update_angle (update_angle[i]),
            .abort_angle  (abort_angle[i]),
            .rd_value     (rot_rd[i])
        );
    end

    servo_led_regs servo_led_i (
        .clock            (clock),
        .reset            (reset),
        .bus              (bus),
        .debug_signals    (debug_signals),
        .servo_control    (servo_control),
        .servo_position   (servo_position),
        .led_test_enable  (led_test_enable),
        .motor_hot_led    (motor_hot_led),
        .ps4_connected_led(ps4_connected_led),
        .pi_connected_led (pi_connected_led),
        .fault_led        (fault_led),
        .rd_value         (servo_rd)
    );

    // Unowned addresses give zero from every block
    always_comb begin
        rd_next = servo_rd;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            rd_next = rd_next | drive_rd[i];
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            rd_next = rd_next | rot_rd[i];
        end
    end

    // One cycle read latency, held between reads
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= rd_next;
        end
    end

endmodule

/* tb/motor_regs_sva.sv */
`timescale 1ns/1ns
// Concurrent checks on the register file top level, attached by bind
// Pulse width, state after reset, read data timing
module motor_regs_sva #(
    parameter int NUM_DRIVE = 4,
    parameter int NUM_ROT   = 2
) (
    input logic                                       clock,
    input logic                                       reset,
    input motor_regs_pkg::reg_bus_t                   bus,
    input motor_regs_pkg::data_t                      rd_data,
    input motor_regs_pkg::drive_ctrl_t [NUM_DRIVE-1:0] drive_ctrl,
    input motor_regs_pkg::rot_ctrl_t [NUM_ROT-1:0]    rot_ctrl,
    input logic [NUM_ROT-1:0]                         update_angle,
    input logic [NUM_ROT-1:0]                         abort_angle
);
    import motor_regs_pkg::*;

    // Strobes never high on two edges in a row
    update_single: assert property (@(posedge clock) disable iff (reset)
        (update_angle & $past(update_angle)) == '0)
        else $error("update_angle stayed high for more than one cycle");

    abort_single: assert property (@(posedge clock) disable iff (reset)
        (abort_angle & $past(abort_angle)) == '0)
        else $error("abort_angle stayed high for more than one cycle");

    // Everything cleared one edge after reset
    reset_state: assert property (@(posedge clock)
        $past(reset) |-> (drive_ctrl == '0 && rot_ctrl == '0 &&
                          update_angle == '0 && abort_angle == '0 && rd_data == '0))
        else $error("controls, pulses or rd_data not zero after reset");

    // Read data moves only on a read
    rd_data_hold: assert property (@(posedge clock) disable iff (reset)
        !$past(bus.read_en) |-> $stable(rd_data))
        else $error("rd_data changed without read_en");

endmodule

bind motor_regs motor_regs_sva #(
    .NUM_DRIVE(NUM_DRIVE),
    .NUM_ROT  (NUM_ROT)
) sva_i (
    .clock       (clock),
    .reset       (reset),
    .bus         (bus),
    .rd_data     (rd_data),
    .drive_ctrl  (drive_ctrl),
    .rot_ctrl    (rot_ctrl),
    .update_angle(update_angle),
    .abort_angle (abort_angle)
);

/* tb/motor_regs_tb.sv */
`timescale 1ns/1ns
// Testbench for the motor register file
// Shadow-register reference model, read comparison, timeout and closing report
module motor_regs_tb;
    import motor_regs_pkg::*;

    localparam int NUM_DRIVE      = 4;
    localparam int NUM_ROT        = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = RESET_CYCLES + 450;  // Two-cycle bus ops plus settle waits
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic                          clock;
    logic                          reset;
    reg_bus_t                      bus;
    data_t                         rd_data;
    logic [NUM_DRIVE-1:0]          drive_fault;
    logic [NUM_DRIVE-1:0]          drive_startup_fail;
    temp_t [NUM_DRIVE-1:0]         drive_temp;
    drive_ctrl_t [NUM_DRIVE-1:0]   drive_ctrl;
    logic [NUM_ROT-1:0]            rot_startup_fail;
    angle_t [NUM_ROT-1:0]          current_angle;
    logic [NUM_ROT-1:0]            angle_done;
    rot_ctrl_t [NUM_ROT-1:0]       rot_ctrl;
    angle_t [NUM_ROT-1:0]          target_angle;
    logic [NUM_ROT-1:0]            update_angle;
    logic [NUM_ROT-1:0]            abort_angle;
    logic [31:0]                   debug_signals;
    data_t                         servo_control;
    data_t [3:0]                   servo_position;
    logic                          led_test_enable;
    logic                          motor_hot_led;
    logic                          ps4_connected_led;
    logic                          pi_connected_led;
    logic                          fault_led;

    data_t  shadow [64];         // Expected writable register contents
    angle_t snap [NUM_ROT];      // Expected angle snapshots
    int     error_count   = 0;
    int     reads_checked = 0;
    int     cycle_count   = 0;

    motor_regs #(
        .NUM_DRIVE(NUM_DRIVE),
        .NUM_ROT  (NUM_ROT)
    ) motor_regs_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;  // 40 ns period
    end

    function automatic addr_t drive_addr(input int i);
        return addr_t'(DRIVE_BASE + DRIVE_STRIDE * i);  // Control, status at +1
    endfunction

    function automatic addr_t rot_addr(input int i);
        return addr_t'(ROT_BASE + ROT_STRIDE * i);
    endfunction

    function automatic data_t random_byte();
        return data_t'($urandom);
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s: expected 0x%0h, got 0x%0h", $time, what, expected, actual);
        end
    endtask

    // Reference model of a write at the edge it lands
    function automatic void model_write(input addr_t a, input data_t d);
        addr_t base;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            if (a == drive_addr(i) || a == ADDR_BCAST_DRIVE || a == ADDR_BCAST_ALL) begin
                shadow[drive_addr(i)] = d;
            end
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            base = rot_addr(i);
            if (a == base || a == ADDR_BCAST_ROT || a == ADDR_BCAST_ALL) begin
                shadow[base] = d;
            end
            if (a == addr_t'(base + 1)) begin
                shadow[a] = d;  // Target low
            end
            if (a == addr_t'(base + 3) && d[CMD_SNAP_BIT]) begin
                snap[i] = current_angle[i];
            end
        end
        if (a == ADDR_SERVO_CTRL || a == ADDR_LED ||
            (a >= SERVO_POS_BASE && a < addr_t'(SERVO_POS_BASE + NUM_SERVO))) begin
            shadow[a] = d;
        end
    endfunction

    // Expected read byte; anything not listed reads zero
    function automatic data_t expected_byte(input addr_t a);
        data_t v;
        addr_t base;
        v = '0;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            if (a == drive_addr(i)) v = shadow[a];
            if (a == addr_t'(drive_addr(i) + 1)) begin
                v = {drive_fault[i], drive_startup_fail[i], drive_temp[i]};
            end
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            base = rot_addr(i);
            if (a == base) v = {shadow[a][7:5], rot_startup_fail[i], shadow[a][3:0]};
            if (a == addr_t'(base + 1)) v = shadow[a];
            if (a == addr_t'(base + 2)) v = snap[i][7:0];
            if (a == addr_t'(base + 3)) v = {angle_done[i], 3'b000, snap[i][11:8]};
        end
        if (a == ADDR_SERVO_CTRL || a == ADDR_LED ||
            (a >= SERVO_POS_BASE && a < addr_t'(SERVO_POS_BASE + NUM_SERVO))) begin
            v = shadow[a];
        end
        for (int j = 0; j < DEBUG_BYTES; j++) begin
            if (a == addr_t'(DEBUG_BASE + j)) v = debug_signals[8*j +: 8];
        end
        return v;
    endfunction

    task automatic write_reg(input addr_t a, input data_t d);
        @(posedge clock);
        bus <= {1'b1, 1'b0, a, d};
        @(posedge clock);
        bus <= '0;  // Write lands at this edge
    endtask

    task automatic read_reg(input addr_t a);
        @(posedge clock);
        bus <= {1'b0, 1'b1, a, 8'h00};
        @(posedge clock);
        bus <= '0;
    endtask

    // New motor inputs, then held long enough for the status samples
    task automatic randomize_inputs();
        @(posedge clock);
        drive_fault        <= 4'($urandom);
        drive_startup_fail <= 4'($urandom);
        drive_temp         <= 24'($urandom);
        rot_startup_fail   <= 2'($urandom);
        current_angle      <= 24'($urandom);
        angle_done         <= 2'($urandom);
        debug_signals      <= $urandom;
        repeat (3) @(posedge clock);
    endtask

    task automatic check_outputs();
        addr_t base;
        @(negedge clock);
        for (int i = 0; i < NUM_DRIVE; i++) begin
            check_value($sformatf("drive_ctrl[%0d]", i), 32'(drive_ctrl[i]),
                        32'(shadow[drive_addr(i)]));
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            base = rot_addr(i);
            check_value($sformatf("rot_ctrl[%0d]", i), 32'(rot_ctrl[i]),
                        32'({shadow[base][7:5], rot_startup_fail[i], shadow[base][3:0]}));
            check_value($sformatf("target_angle[%0d]", i), 32'(target_angle[i]),
                        32'({shadow[base][3:0], shadow[addr_t'(base + 1)]}));
        end
        check_value("servo_control", 32'(servo_control), 32'(shadow[ADDR_SERVO_CTRL]));
        for (int j = 0; j < NUM_SERVO; j++) begin
            check_value($sformatf("servo_position[%0d]", j), 32'(servo_position[j]),
                        32'(shadow[addr_t'(SERVO_POS_BASE + j)]));
        end
        check_value("LED outputs", 32'({led_test_enable, motor_hot_led, ps4_connected_led,
                                        pi_connected_led, fault_led}),
                    32'(shadow[ADDR_LED][4:0]));
    endtask

    task automatic read_controls();
        for (int i = 0; i < NUM_DRIVE; i++) read_reg(drive_addr(i));
        for (int i = 0; i < NUM_ROT; i++) read_reg(rot_addr(i));
    endtask

    // Called right after a command write lands
    task automatic expect_pulse(input int ch, input logic upd, input logic abt);
        @(negedge clock);
        check_value("update_angle pulse", 32'(update_angle), upd ? 32'(1) << ch : 32'd0);
        check_value("abort_angle pulse", 32'(abort_angle), abt ? 32'(1) << ch : 32'd0);
        @(negedge clock);
        check_value("update_angle after pulse", 32'(update_angle), 32'd0);
        check_value("abort_angle after pulse", 32'(abort_angle), 32'd0);
    endtask

    // Model update and read comparison, one cycle after each read
    initial begin : read_compare
        addr_t rd_addr;
        data_t exp_byte;
        foreach (shadow[k]) shadow[k] = '0;  // Writable registers clear on reset
        foreach (snap[k]) snap[k] = '0;
        forever begin
            @(posedge clock);
            if (!reset && bus.write_en) model_write(bus.address, bus.wr_data);
            if (!reset && bus.read_en) begin
                rd_addr  = bus.address;
                exp_byte = expected_byte(rd_addr);
                @(negedge clock);
                check_value($sformatf("read 0x%02h", rd_addr), 32'(rd_data), 32'(exp_byte));
                reads_checked++;
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(44));
        reset              = 1'b1;
        bus                = '0;
        drive_fault        = '0;
        drive_startup_fail = '0;
        drive_temp         = '0;
        rot_startup_fail   = '0;
        current_angle      = '0;
        angle_done         = '0;
        debug_signals      = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        check_outputs();  // Shadow is all zero here
        check_value("update_angle after reset", 32'(update_angle), 32'd0);
        check_value("abort_angle after reset", 32'(abort_angle), 32'd0);
        check_value("rd_data after reset", 32'(rd_data), 32'd0);

        // Control readback per channel
        repeat (2) begin
            randomize_inputs();
            for (int i = 0; i < NUM_DRIVE; i++) begin
                write_reg(drive_addr(i), random_byte());
                read_reg(drive_addr(i));
                check_outputs();
            end
            for (int i = 0; i < NUM_ROT; i++) begin
                write_reg(rot_addr(i), random_byte());
                read_reg(rot_addr(i));
                check_outputs();
            end
        end

        // Broadcasts and the reserved address
        write_reg(ADDR_BCAST_DRIVE, random_byte());
        check_outputs();
        read_controls();
        write_reg(ADDR_BCAST_ROT, random_byte());
        check_outputs();
        read_controls();
        write_reg(ADDR_BCAST_ALL, random_byte());
        check_outputs();
        read_controls();
        write_reg(6'h00, random_byte());  // No effect
        check_outputs();
        read_controls();
        for (int a = 0; a < 64; a++) read_reg(addr_t'(a));  // Whole map, gaps read zero

        // Status and debug sampling
        repeat (3) begin
            randomize_inputs();
            for (int i = 0; i < NUM_DRIVE; i++) read_reg(addr_t'(drive_addr(i) + 1));
            for (int j = 0; j < DEBUG_BYTES; j++) read_reg(addr_t'(DEBUG_BASE + j));
        end

        // Target angle, command pulses, snapshot
        for (int i = 0; i < NUM_ROT; i++) begin
            write_reg(addr_t'(rot_addr(i) + 1), random_byte());
            write_reg(rot_addr(i), random_byte());
            check_outputs();
            write_reg(addr_t'(rot_addr(i) + 3), 8'h20);
            expect_pulse(i, 1'b1, 1'b0);
            write_reg(addr_t'(rot_addr(i) + 3), 8'h10);
            expect_pulse(i, 1'b0, 1'b1);
            write_reg(addr_t'(rot_addr(i) + 3), 8'h30);
            expect_pulse(i, 1'b1, 1'b1);
            randomize_inputs();
            write_reg(addr_t'(rot_addr(i) + 3), 8'h40);
            randomize_inputs();  // Angle moves on after the snapshot
            read_reg(addr_t'(rot_addr(i) + 2));
            read_reg(addr_t'(rot_addr(i) + 3));
            read_reg(addr_t'(rot_addr(i) + 1));
        end

        // Servo and LED registers
        write_reg(ADDR_SERVO_CTRL, random_byte());
        for (int j = 0; j < NUM_SERVO; j++) write_reg(addr_t'(SERVO_POS_BASE + j), random_byte());
        write_reg(ADDR_LED, random_byte());
        check_outputs();
        read_reg(ADDR_SERVO_CTRL);
        for (int j = 0; j < NUM_SERVO; j++) read_reg(addr_t'(SERVO_POS_BASE + j));
        read_reg(ADDR_LED);

        @(negedge clock);
        @(posedge clock);  // Last comparison done
        $display("Closing report: %0d error(s) in %0d compared reads", error_count,
                 reads_checked);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/motor_regs_pkg.sv
rtl/drive_channel.sv
rtl/rotation_channel.sv
rtl/servo_led_regs.sv
rtl/motor_regs.sv
tb/motor_regs_sva.sv
tb/motor_regs_tb.sv

/* Makefile */
# Verilator build and run for the motor register file
TOP := motor_regs_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

# Pass only when the simulation prints the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
